/* design/bitmap_addr.sv */
// draw coordinate to framebuffer address, three register stages
// clip test, row multiply, column add, with colour and valid alongside
`timescale 1ns/1ns
`include "fb_params.svh"

module bitmap_addr (
    input  logic          clk_sys,
    input  logic          rst_sys,
    input  fb_pkg::cord_t x,
    input  fb_pkg::cord_t y,
    input  fb_pkg::cidx_t cidx,
    input  logic          valid,     // pixel present at x/y
    output fb_pkg::addr_t addr,
    output fb_pkg::cidx_t cidx_out,
    output logic          we         // valid and inside the buffer
);

    fb_pkg::cord_t x1, y1;           // stage 1 coordinates
    fb_pkg::cidx_t cidx1, cidx2;
    fb_pkg::addr_t col2, row2;       // stage 2 column and row base
    logic          clip1, clip2;
    logic          valid1, valid2;

    always_ff @(posedge clk_sys) begin
        // stage 1: clip test, negative or past the edge
        clip1  <= (x < 0 || y < 0 || x >= `FB_WIDTH || y >= `FB_HEIGHT);
        x1     <= x;
        y1     <= y;
        cidx1  <= cidx;
        valid1 <= valid;

        // stage 2: row base, only meaningful when not clipped
        row2   <= fb_pkg::addr_t'(y1 * `FB_WIDTH);
        col2   <= fb_pkg::addr_t'(x1);
        clip2  <= clip1;
        cidx2  <= cidx1;
        valid2 <= valid1;

        // stage 3: full address and aligned write enable
        addr     <= row2 + col2;
        cidx_out <= cidx2;
        we       <= valid2 && !clip2;

        if (rst_sys) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            we     <= 1'b0;
        end
    end

endmodule

/* design/display_timing.sv */
// raster counters for the small simulation display
// screen coordinates, sync pulses, data enable and frame strobe
`timescale 1ns/1ns
`include "fb_params.svh"

module display_timing (
    input  logic          clk_sys,
    input  logic          rst_sys,
    output fb_pkg::cord_t sx,      // horizontal position
    output fb_pkg::cord_t sy,      // vertical position
    output logic          hsync,
    output logic          vsync,
    output logic          de,      // active video
    output logic          frame    // start of frame
);

    // sync windows, active region starts at 0
    localparam int HS_START = `H_ACTIVE + `H_FRONT;
    localparam int HS_END   = HS_START + `H_SYNC;
    localparam int VS_START = `V_ACTIVE + `V_FRONT;
    localparam int VS_END   = VS_START + `V_SYNC;
    localparam int H_LAST   = `H_TOTAL - 1;
    localparam int V_LAST   = `V_TOTAL - 1;

    always_ff @(posedge clk_sys) begin
        if (sx == fb_pkg::cord_t'(H_LAST)) begin  // end of line
            sx <= '0;
            if (sy == fb_pkg::cord_t'(V_LAST)) sy <= '0;  // wrap to top
            else sy <= sy + fb_pkg::cord_t'(1);
        end else begin
            sx <= sx + fb_pkg::cord_t'(1);
        end
        if (rst_sys) begin
            sx <= '0;
            sy <= '0;
        end
    end

    // flags decoded straight from the counters
    always_comb begin
        hsync = (sx >= HS_START && sx < HS_END) ? `SYNC_ACTIVE : ~`SYNC_ACTIVE;
        vsync = (sy >= VS_START && sy < VS_END) ? `SYNC_ACTIVE : ~`SYNC_ACTIVE;
        de    = (sx < `H_ACTIVE && sy < `V_ACTIVE);
        frame = (sx == 0 && sy == 0);  // single cycle per frame
    end

endmodule

/* design/fb_draw_top.sv */
// framebuffer draw subsystem top level
// rectangle fill, address pipeline, framebuffer ram, raster timing, scan-out
`timescale 1ns/1ns

module fb_draw_top (
    input  logic          clk_sys,
    input  logic          rst_sys,
    input  logic          draw_start,
    input  fb_pkg::cord_t draw_x0,
    input  fb_pkg::cord_t draw_y0,
    input  fb_pkg::cord_t draw_x1,
    input  fb_pkg::cord_t draw_y1,
    input  fb_pkg::cidx_t draw_cidx,
    output logic          draw_busy,
    output logic          draw_done,
    output logic          vga_hsync,
    output logic          vga_vsync,
    output logic          vga_de,
    output fb_pkg::chan_t vga_r,
    output fb_pkg::chan_t vga_g,
    output fb_pkg::chan_t vga_b
);

    // draw side
    fb_pkg::cord_t drw_x, drw_y;
    fb_pkg::cidx_t drw_cidx;
    logic          drawing;
    fb_pkg::addr_t fb_addr_write;
    fb_pkg::cidx_t fb_colr_write;
    logic          fb_we;

    // display side
    fb_pkg::cord_t sx, sy;
    logic          hsync, vsync, de;
    fb_pkg::addr_t fb_addr_read;
    fb_pkg::cidx_t fb_colr_read;

    rect_fill rect_fill_inst (
        .clk_sys, .rst_sys,
        .start(draw_start),
        .x0(draw_x0), .y0(draw_y0), .x1(draw_x1), .y1(draw_y1),
        .cidx(draw_cidx),
        .drw_x, .drw_y, .drw_cidx, .drawing,
        .busy(draw_busy), .done(draw_done)
    );

    bitmap_addr bitmap_addr_inst (  // 3 cycle latency
        .clk_sys, .rst_sys,
        .x(drw_x), .y(drw_y), .cidx(drw_cidx), .valid(drawing),
        .addr(fb_addr_write), .cidx_out(fb_colr_write), .we(fb_we)
    );

    fb_ram fb_ram_inst (
        .clk_sys, .we(fb_we),
        .addr_write(fb_addr_write), .data_in(fb_colr_write),
        .addr_read(fb_addr_read), .data_out(fb_colr_read)
    );

    display_timing display_timing_inst (
        .clk_sys, .rst_sys,
        .sx, .sy, .hsync, .vsync, .de,
        .frame()
    );

    scan_out scan_out_inst (
        .clk_sys, .rst_sys,
        .sx, .sy, .hsync, .vsync, .de,
        .fb_addr_read, .fb_colr_read,
        .vga_hsync, .vga_vsync, .vga_de,
        .vga_r, .vga_g, .vga_b
    );

endmodule

/* design/fb_pkg.sv */
// shared types for the framebuffer draw subsystem
// coordinates, addresses, colour index and colour vectors, draw FSM states
`include "fb_params.svh"

package fb_pkg;

    typedef logic signed [15:0]        cord_t;  // screen and draw coordinate
    typedef logic [`FB_ADDRW-1:0]      addr_t;  // framebuffer word address
    typedef logic [3:0]                cidx_t;  // palette index, one per pixel
    typedef logic [11:0]               colr_t;  // rgb 4:4:4
    typedef logic [3:0]                chan_t;  // single colour channel

    // rectangle fill control
    typedef enum logic [1:0] {
        IDLE,  // waiting for start
        INIT,  // load first corner
        FILL,  // one pixel per cycle
        DONE   // done pulse out
    } draw_state_t;

endpackage

/* design/fb_ram.sv */
// simple dual-port framebuffer ram
// one write port, one registered read port, cleared to index 0
`timescale 1ns/1ns
`include "fb_params.svh"

module fb_ram (
    input  logic          clk_sys,
    input  logic          we,
    input  fb_pkg::addr_t addr_write,
    input  fb_pkg::cidx_t data_in,
    input  fb_pkg::addr_t addr_read,
    output fb_pkg::cidx_t data_out
);

    fb_pkg::cidx_t mem [0:`FB_PIXELS-1];

    initial begin
        for (int i = 0; i < `FB_PIXELS; i++) mem[i] = '0;  // empty buffer
    end

    always_ff @(posedge clk_sys) begin
        if (we) mem[addr_write] <= data_in;
        data_out <= mem[addr_read];  // read-before-write on same address
    end

endmodule

/* design/rect_fill.sv */
// filled rectangle draw control
// latches the corners on start and walks the pixels row by row
`timescale 1ns/1ns

module rect_fill (
    input  logic          clk_sys,
    input  logic          rst_sys,
    input  logic          start,     // one-cycle request
    input  fb_pkg::cord_t x0,        // top left, inclusive
    input  fb_pkg::cord_t y0,
    input  fb_pkg::cord_t x1,        // bottom right, inclusive
    input  fb_pkg::cord_t y1,
    input  fb_pkg::cidx_t cidx,
    output fb_pkg::cord_t drw_x,     // pixel being drawn
    output fb_pkg::cord_t drw_y,
    output fb_pkg::cidx_t drw_cidx,
    output logic          drawing,   // drw_x/drw_y valid
    output logic          busy,
    output logic          done       // pulse after last pixel
);

    fb_pkg::draw_state_t state;
    fb_pkg::cord_t       x0_r, y0_r, x1_r, y1_r;  // latched corners

    always_ff @(posedge clk_sys) begin
        done <= 1'b0;  // pulse by default
        case (state)
            fb_pkg::IDLE, fb_pkg::DONE: begin
                if (start) begin  // busy is low here
                    x0_r     <= x0;
                    y0_r     <= y0;
                    x1_r     <= x1;
                    y1_r     <= y1;
                    drw_cidx <= cidx;
                    busy     <= 1'b1;
                    state    <= fb_pkg::INIT;
                end else begin
                    state <= fb_pkg::IDLE;
                end
            end
            fb_pkg::INIT: begin
                drw_x   <= x0_r;  // first pixel of first row
                drw_y   <= y0_r;
                drawing <= 1'b1;
                state   <= fb_pkg::FILL;
            end
            fb_pkg::FILL: begin
                if (drw_x == x1_r) begin  // end of row
                    if (drw_y == y1_r) begin  // last pixel now on the bus
                        drawing <= 1'b0;
                        busy    <= 1'b0;
                        done    <= 1'b1;
                        state   <= fb_pkg::DONE;
                    end else begin
                        drw_x <= x0_r;
                        drw_y <= drw_y + fb_pkg::cord_t'(1);
                    end
                end else begin
                    drw_x <= drw_x + fb_pkg::cord_t'(1);  // next column
                end
            end
            default: state <= fb_pkg::IDLE;
        endcase
        if (rst_sys) begin
            state   <= fb_pkg::IDLE;
            busy    <= 1'b0;
            done    <= 1'b0;
            drawing <= 1'b0;
        end
    end

endmodule

/* design/scan_out.sv */
// raster scan of the framebuffer with 2x scaling
// read address, fixed 16-entry palette, background and blanking, delayed sync
`timescale 1ns/1ns
`include "fb_params.svh"

module scan_out (
    input  logic          clk_sys,
    input  logic          rst_sys,
    input  fb_pkg::cord_t sx,
    input  fb_pkg::cord_t sy,
    input  logic          hsync,
    input  logic          vsync,
    input  logic          de,
    output fb_pkg::addr_t fb_addr_read,
    input  fb_pkg::cidx_t fb_colr_read,   // arrives one cycle after the address
    output logic          vga_hsync,
    output logic          vga_vsync,
    output logic          vga_de,
    output fb_pkg::chan_t vga_r,
    output fb_pkg::chan_t vga_g,
    output fb_pkg::chan_t vga_b
);

    localparam int SCALE_SH = $clog2(`FB_SCALE);  // divide by scale
    localparam int ROW_SH   = $clog2(`FB_WIDTH);  // multiply by width
    localparam int PAINT_X1 = `FB_OFFX + `FB_WIDTH * `FB_SCALE;   // exclusive
    localparam int PAINT_Y1 = `FB_OFFY + `FB_HEIGHT * `FB_SCALE;

    logic [`SCAN_LAT-1:0] hs_q, vs_q, de_q;  // sync and de delay lines
    logic [1:0]           paint_q;           // paint flag, stages 1 and 2
    logic                 paint;
    fb_pkg::cord_t        bx, by;            // buffer coordinate of sx/sy
    fb_pkg::colr_t        pal_colr;

    // stage 1 combinational part, position relative to buffer origin
    always_comb begin
        paint = (sx >= `FB_OFFX && sx < PAINT_X1 && sy >= `FB_OFFY && sy < PAINT_Y1);
        bx    = (sx - fb_pkg::cord_t'(`FB_OFFX)) >>> SCALE_SH;
        by    = (sy - fb_pkg::cord_t'(`FB_OFFY)) >>> SCALE_SH;
    end

    always_ff @(posedge clk_sys) begin
        fb_addr_read <= fb_pkg::addr_t'((by <<< ROW_SH) + bx);  // stage 1
        paint_q <= {paint_q[0], paint};
        hs_q    <= {hs_q[`SCAN_LAT-2:0], hsync};
        vs_q    <= {vs_q[`SCAN_LAT-2:0], vsync};
        de_q    <= {de_q[`SCAN_LAT-2:0], de};
        if (rst_sys) begin
            hs_q    <= {`SCAN_LAT{~`SYNC_ACTIVE}};  // sync idle
            vs_q    <= {`SCAN_LAT{~`SYNC_ACTIVE}};
            de_q    <= '0;
            paint_q <= '0;
        end
    end

    // fixed palette, index to rgb 4:4:4
    always_comb begin
        case (fb_colr_read)
            4'h0: pal_colr = 12'h112;
            4'h1: pal_colr = 12'h525;
            4'h2: pal_colr = 12'hB35;
            4'h3: pal_colr = 12'hE75;
            4'h4: pal_colr = 12'hFC7;
            4'h5: pal_colr = 12'hAE7;
            4'h6: pal_colr = 12'h3B6;
            4'h7: pal_colr = 12'h267;
            4'h8: pal_colr = 12'h236;
            4'h9: pal_colr = 12'h35C;
            4'hA: pal_colr = 12'h4AF;
            4'hB: pal_colr = 12'h7EF;
            4'hC: pal_colr = 12'hFFF;
            4'hD: pal_colr = 12'h9BC;
            4'hE: pal_colr = 12'h568;
            default: pal_colr = 12'h335;  // index F
        endcase
    end

    // stage 3 output register, black during blanking
    always_ff @(posedge clk_sys) begin
        if (!de_q[`SCAN_LAT-2]) {vga_r, vga_g, vga_b} <= '0;
        else if (paint_q[1]) {vga_r, vga_g, vga_b} <= pal_colr;
        else {vga_r, vga_g, vga_b} <= `BG_COLR;  // outside the buffer
    end

    assign vga_hsync = hs_q[`SCAN_LAT-1];
    assign vga_vsync = vs_q[`SCAN_LAT-1];
    assign vga_de    = de_q[`SCAN_LAT-1];

endmodule

/* include/fb_params.svh */
// framebuffer geometry, display timing and scan-out constants
// shared by the package, the RTL and the testbench
`ifndef FB_PARAMS_SVH
`define FB_PARAMS_SVH

// framebuffer size
`define FB_WIDTH  32   // pixels per row
`define FB_HEIGHT 16   // rows
`define FB_PIXELS 512  // FB_WIDTH * FB_HEIGHT
`define FB_ADDRW  9    // address bits for FB_PIXELS

// placement of the scaled buffer on screen
`define FB_SCALE  2    // each buffer pixel covers SCALE x SCALE screen pixels
`define FB_OFFX   8    // screen column of buffer x=0
`define FB_OFFY   4    // screen row of buffer y=0

// horizontal timing, active first then porches and sync
`define H_ACTIVE  80
`define H_FRONT   4
`define H_SYNC    8
`define H_BACK    8
`define H_TOTAL   (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)  // 100

// vertical timing in lines
`define V_ACTIVE  40
`define V_FRONT   2
`define V_SYNC    2
`define V_BACK    4
`define V_TOTAL   (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)  // 48

`define SYNC_ACTIVE 1'b0     // sync pulses are active low
`define BG_COLR     12'h137  // screen colour outside the buffer
`define SCAN_LAT    3        // raster position to registered output

`endif

/* sim/fb_draw_chk.sv */
// assertions on the draw handshake and the display sync outputs
// bound into the framebuffer draw top level
`timescale 1ns/1ns
`include "fb_params.svh"

module fb_draw_chk (
    input logic clk_sys,
    input logic rst_sys,
    input logic draw_busy,
    input logic draw_done,
    input logic vga_hsync,
    input logic vga_vsync,
    input logic vga_de
);

    int assert_fails = 0;  // failed assertion count

    done_pulse: assert property (@(posedge clk_sys) disable iff (rst_sys)
        draw_done |=> !draw_done)  // single cycle only
        else begin
            $error("draw_done stayed high for more than one cycle");
            assert_fails++;
        end

    busy_done_excl: assert property (@(posedge clk_sys) disable iff (rst_sys)
        !(draw_busy && draw_done))
        else begin
            $error("draw_busy and draw_done high in the same cycle");
            assert_fails++;
        end

    // no video inside either sync pulse
    de_outside_sync: assert property (@(posedge clk_sys) disable iff (rst_sys)
        vga_de |-> (vga_hsync && vga_vsync))
        else begin
            $error("vga_de high during a sync pulse");
            assert_fails++;
        end

    hsync_width: assert property (@(posedge clk_sys) disable iff (rst_sys)
        $fell(vga_hsync) |-> (!vga_hsync) [*`H_SYNC] ##1 vga_hsync)
        else begin
            $error("hsync low pulse not %0d cycles long", `H_SYNC);
            assert_fails++;
        end

endmodule

bind fb_draw_top fb_draw_chk chk (
    .clk_sys, .rst_sys, .draw_busy, .draw_done, .vga_hsync, .vga_vsync, .vga_de
);

/* sim/fb_draw_mon.sv */
// probe and draw event checker for the framebuffer testbench
// rebuilds the output raster position from the sync falling edges
`timescale 1ns/1ns
`include "fb_params.svh"

module fb_draw_mon (
    input  logic          clk_sys,
    input  logic          rst_sys,
    input  logic          draw_done,
    input  logic          vga_hsync,
    input  logic          vga_vsync,
    input  logic          vga_de,
    input  fb_pkg::chan_t vga_r,
    input  fb_pkg::chan_t vga_g,
    input  fb_pkg::chan_t vga_b,
    output int            tests,
    output int            errors
);

    localparam int HS_COL = `H_ACTIVE + `H_FRONT;  // column where hsync falls
    localparam int VS_ROW = `V_ACTIVE + `V_FRONT;  // row where vsync falls

    int            ox, oy;       // raster position of the sampled outputs
    int            frame_no;     // first full frame after lock is 0
    int            done_seen;
    logic          locked;       // position known
    logic          hs_prev, vs_prev;
    logic          de_s;         // sampled data enable
    fb_pkg::colr_t colr;         // sampled output colour

    initial begin
        tests     = 0;
        errors    = 0;
        done_seen = 0;
        frame_no  = -1;
    end

    task automatic report_failure(input string msg);
        errors++;
        $display("FAIL %s", msg);
    endtask

    always @(posedge clk_sys) begin : track_raster
        int nx;
        int ny;
        nx = ox + 1;  // predicted position
        ny = oy;
        if (nx == `H_TOTAL) begin
            nx = 0;
            ny = (oy + 1) % `V_TOTAL;
        end
        if (rst_sys) begin
            locked  = 1'b0;
            hs_prev = 1'b1;
            vs_prev = 1'b1;
        end else if (vs_prev && !vga_vsync) begin  // vsync edge resyncs
            if (locked && (nx != 0 || ny != VS_ROW))
                report_failure($sformatf("vsync fell at %0d,%0d, not at 0,%0d", nx, ny, VS_ROW));
            if (!locked) frame_no = -1;
            locked = 1'b1;
            ox = 0;
            oy = VS_ROW;
        end else begin
            if (locked && nx == 0 && ny == VS_ROW)
                report_failure($sformatf("vsync did not fall at 0,%0d", VS_ROW));
            ox = nx;
            oy = ny;
            if (nx == 0 && ny == 0) frame_no++;  // top left of a new frame
        end
        // one hsync fall per line, at its own column
        if (locked && ((hs_prev && !vga_hsync) != (ox == HS_COL)))
            report_failure($sformatf("hsync fall wrong at column %0d, expected only at %0d",
                                     ox, HS_COL));
        if (!rst_sys && draw_done) done_seen++;
        colr    = {vga_r, vga_g, vga_b};
        de_s    = vga_de;
        hs_prev = vga_hsync;
        vs_prev = vga_vsync;
    end

    // waits for the screen position, read between clock edges
    task automatic check_pixel(input string name, input int frame, input int px, input int py,
                               input fb_pkg::colr_t exp_colr);
        logic exp_de;
        exp_de = (px < `H_ACTIVE && py < `V_ACTIVE);  // active video comes first
        while (!(locked && frame_no == frame && ox == px && oy == py)) begin
            if (locked && frame_no > frame) break;  // position already passed
            @(negedge clk_sys);
        end
        tests++;
        if (frame_no != frame) begin
            report_failure($sformatf("probe %s missed, frame %0d is over", name, frame));
        end else if (colr !== exp_colr) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp_colr, colr);
        end else if (de_s !== exp_de) begin
            errors++;
            $display("ERR %s expected de %b actual de %b", name, exp_de, de_s);
        end else begin
            $display("ok  %s colour %h", name, colr);
        end
    endtask

    task automatic check_done_count(input string name, input int exp_count);
        tests++;
        if (done_seen != exp_count) begin
            errors++;
            $display("ERR %s expected %0d actual %0d", name, exp_count, done_seen);
        end else begin
            $display("ok  %s count %0d", name, done_seen);
        end
    endtask

endmodule

/* sim/fb_draw_patterns.txt */
# R x0 y0 x1 y1 cidx, B same but pulsed while busy, D name done_count
# P name frame sx sy colour, screen position and 12-bit rgb hex, raster order
P empty_bg_left 0 7 4 137
P empty_paint 0 8 4 112
P empty_hblank 0 85 10 000
P empty_paint_last 0 71 35 112
P empty_vblank 0 20 44 000
R 2 1 5 3 9
P rect_left_nb 1 11 6 112
P rect_top_left 1 12 6 35c
P rect_block 1 13 7 35c
P rect_bot_right 1 19 11 35c
P rect_right_nb 1 20 11 112
R -3 -2 34 5 4
P clip_top_left 3 8 4 fc7
P clip_top_right 3 71 4 fc7
P clip_last_row 3 40 15 fc7
P clip_no_wrap_row6 3 8 16 112
P clip_no_wrap_bottom 3 71 35 112
R 10 8 15 10 2
R 13 9 20 12 c
B -3 -3 40 20 f
P busy_ignored_row6 5 70 16 112
P ovl_first_only 5 28 20 b35
P ovl_later_wins 5 38 24 fff
P ovl_second_only 5 48 28 fff
P busy_ignored_bottom 5 8 34 112
D done_count 4

/* sim/fb_draw_tb.sv */
// testbench top for the framebuffer draw subsystem
// clock and reset, pattern file commands, draw requests, watchdog
`timescale 1ns/1ns
`include "fb_params.svh"

module fb_draw_tb;

    localparam int CLK_PERIOD = 4;

    logic          clk_sys;
    logic          rst_sys;
    logic          draw_start;
    fb_pkg::cord_t draw_x0, draw_y0, draw_x1, draw_y1;
    fb_pkg::cidx_t draw_cidx;
    logic          draw_busy, draw_done;
    logic          vga_hsync, vga_vsync, vga_de;
    fb_pkg::chan_t vga_r, vga_g, vga_b;
    int            tests, errors;   // from the monitor
    int            nframes = 0;     // frames named by probes, plus one
    logic          loaded;
    string         lines[$];        // pattern file, one entry per line

    fb_draw_top dut (.*);

    fb_draw_mon mon (
        .clk_sys, .rst_sys, .draw_done,
        .vga_hsync, .vga_vsync, .vga_de, .vga_r, .vga_g, .vga_b,
        .tests, .errors
    );

    initial clk_sys = 1'b0;
    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic load_patterns(output logic ok);
        int    fd;
        int    frame;
        int    max_frame;
        string line;
        string tag;
        string name;
        max_frame = 1;
        fd = $fopen("sim/fb_draw_patterns.txt", "r");
        ok = (fd != 0);
        if (!ok) $display("pattern file sim/fb_draw_patterns.txt could not be opened");
        while (ok && !$feof(fd)) begin
            if ($fgets(line, fd) > 0) begin
                lines.push_back(line);
                if ($sscanf(line, "%s %s %d", tag, name, frame) == 3 && tag == "P"
                        && frame >= max_frame)
                    max_frame = frame + 1;  // probes name frame 0 upward
            end
        end
        if (ok) $fclose(fd);
        nframes = max_frame;  // arms the watchdog
    endtask

    task automatic issue_start(input int x0, input int y0, input int x1, input int y1,
                               input logic [31:0] cidx);
        draw_x0    = fb_pkg::cord_t'(x0);
        draw_y0    = fb_pkg::cord_t'(y0);
        draw_x1    = fb_pkg::cord_t'(x1);
        draw_y1    = fb_pkg::cord_t'(y1);
        draw_cidx  = fb_pkg::cidx_t'(cidx);
        draw_start = 1'b1;  // one-cycle strobe
        next_cycle();
        draw_start = 1'b0;
    endtask

    // R and B are rectangles, P a pixel probe, D the done count
    task automatic run_line(input string line);
        string       tag;
        string       name;
        int          a, b, c, d;
        int          n;
        logic [31:0] h;
        if ($sscanf(line, "%s", tag) != 1) tag = "";
        case (tag)
            "R", "B": begin
                n = $sscanf(line, "%s %d %d %d %d %h", tag, a, b, c, d, h);
                if (n != 6) begin
                    mon.report_failure("rectangle line in the pattern file has missing fields");
                end else begin
                    if (tag == "B" && !draw_busy)
                        mon.report_failure("a start meant for a busy DUT found it idle");
                    while (tag == "R" && draw_busy) next_cycle();
                    issue_start(a, b, c, d, h);
                end
            end
            "P": begin
                n = $sscanf(line, "%s %s %d %d %d %h", tag, name, a, b, c, h);
                if (n != 6) begin
                    mon.report_failure("probe line in the pattern file has missing fields");
                end else begin
                    mon.check_pixel(name, a, b, c, fb_pkg::colr_t'(h));
                    next_cycle();  // back onto the drive point
                end
            end
            "D": begin
                n = $sscanf(line, "%s %s %d", tag, name, a);
                if (n != 3) begin
                    mon.report_failure("done count line in the pattern file has missing fields");
                end else begin
                    while (draw_busy) next_cycle();
                    next_cycle();  // let the last done pulse be seen
                    mon.check_done_count(name, a);
                end
            end
            default: ;  // comment or empty line
        endcase
    endtask

    initial begin
        rst_sys    = 1'b1;
        draw_start = 1'b0;
        draw_x0    = '0;
        draw_y0    = '0;
        draw_x1    = '0;
        draw_y1    = '0;
        draw_cidx  = '0;
        load_patterns(loaded);
        repeat (10) @(posedge clk_sys);
        #1;
        rst_sys = 1'b0;
        foreach (lines[i]) run_line(lines[i]);
        $display("tests run: %0d, errors: %0d, assertion failures: %0d",
                 tests, errors, dut.chk.assert_fails);
        if (loaded && tests > 0 && errors == 0 && dut.chk.assert_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // two spare frames cover reset and raster lock
    initial begin : watchdog
        wait (nframes > 0);
        #((nframes + 2) * `H_TOTAL * `V_TOTAL * CLK_PERIOD);
        $display("watchdog expired after %0d frames with tests still running", nframes + 2);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
design/fb_pkg.sv
design/display_timing.sv
design/rect_fill.sv
design/bitmap_addr.sv
design/fb_ram.sv
design/scan_out.sv
design/fb_draw_top.sv
sim/fb_draw_mon.sv
sim/fb_draw_chk.sv
sim/fb_draw_tb.sv
